/* include/pcore_params.svh */
`ifndef PCORE_PARAMS_SVH
`define PCORE_PARAMS_SVH

// bus and line geometry
`define PCORE_ADDR_W      16
`define PCORE_LINE_W      64
`define PCORE_STRB_W      8
`define PCORE_DMEM_BYTES  32768
`define PCORE_SLOT_PTR_W  3
`define PCORE_CREDITS     4

// io write side, offsets within the io window
`define PCORE_IO_DESC       7'h00
`define PCORE_IO_DRAM       7'h08
`define PCORE_IO_SETTING    7'h10
`define PCORE_IO_SLOT_INFO  7'h18
`define PCORE_IO_SEND       7'h38
`define PCORE_IO_TAKE       7'h39
`define PCORE_IO_APPLY      7'h3A
`define PCORE_IO_SLOT_WR    7'h3B
`define PCORE_IO_TIMER_RST  7'h3C
`define PCORE_IO_ERR_CLR    7'h3D

// io read side
`define PCORE_IO_RD_DESC    7'h40
`define PCORE_IO_RD_SETTING 7'h48
`define PCORE_IO_STATUS     7'h50
`define PCORE_IO_ID         7'h54
`define PCORE_IO_TIMER      7'h58
`define PCORE_IO_SPACE      32'h60

`endif

/* src/pcore_pkg.sv */
`include "pcore_params.svh"

package pcore_pkg;

  // processor side command, size 0 byte, 1 half, 2 word
  typedef struct packed {
    logic                     wr;
    logic [`PCORE_ADDR_W-1:0] addr;
    logic [31:0]              data;
    logic [1:0]               size;
  } bus_cmd_t;

  typedef struct packed {
    logic [31:0] data;
    logic        err;
  } bus_rsp_t;

  // data memory line access
  typedef struct packed {
    logic                     en;
    logic [`PCORE_STRB_W-1:0] strb;
    logic [`PCORE_ADDR_W-1:0] addr;
    logic [`PCORE_LINE_W-1:0] data;
  } line_req_t;

  // accepted io access, offset within the io window
  typedef struct packed {
    logic        wr;
    logic [6:0]  off;
    logic [31:0] data;
    logic [3:0]  mask;
  } io_req_t;

  typedef struct packed {
    logic [63:0] desc;
    logic [63:0] dram_addr;
  } desc_t;

  typedef struct packed {
    logic [`PCORE_SLOT_PTR_W-1:0] ptr;
    logic [`PCORE_ADDR_W-1:0]     addr;
  } slot_t;

endpackage

/* src/pcore_bus_adapter.sv */
`timescale 1ns/1ps
`include "pcore_params.svh"

module pcore_bus_adapter (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     cmd_valid,
  input  pcore_pkg::bus_cmd_t      cmd,
  input  logic                     mem_ready,
  input  logic [`PCORE_LINE_W-1:0] mem_rd_data,
  input  logic [31:0]              io_rd_data,
  input  logic                     err_any,
  output pcore_pkg::line_req_t     line_req,
  output logic                     io_valid,
  output pcore_pkg::io_req_t       io_req,
  output logic                     rsp_valid,
  output pcore_pkg::bus_rsp_t      rsp
);

  logic                     accept;
  logic                     is_io;
  logic [3:0]               word_mask;
  logic [`PCORE_STRB_W-1:0] line_mask;
  logic                     half_r;
  logic                     io_rd_r;
  logic                     rsp_valid_r;

  assign accept = cmd_valid && mem_ready;
  // top address bit selects the io window
  assign is_io  = cmd.addr[`PCORE_ADDR_W-1];

  // size code to byte mask within the word
  always_comb begin
    case (cmd.size)
      2'd0:    word_mask = 4'b0001 << cmd.addr[1:0];
      2'd1:    word_mask = 4'b0011 << cmd.addr[1:0];
      default: word_mask = 4'b1111;
    endcase
  end

  assign line_mask = {{(`PCORE_STRB_W-4){1'b0}}, word_mask} << {cmd.addr[2], 2'b00};

  // write data comes lane aligned, only the line half moves
  always_comb begin
    line_req.en   = accept && !is_io;
    line_req.strb = cmd.wr ? line_mask : '0;
    line_req.addr = cmd.addr;
    line_req.data = {32'd0, cmd.data} << {cmd.addr[2], 5'd0};
  end

  always_comb begin
    io_valid    = accept && is_io;
    io_req.wr   = cmd.wr;
    io_req.off  = cmd.addr[6:0];
    io_req.data = cmd.data;
    io_req.mask = word_mask;
  end

  // which half of the returned line holds the word
  always_ff @(posedge clk) begin
    half_r <= cmd.addr[2];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid_r <= 1'b0;
      io_rd_r     <= 1'b0;
    end else begin
      rsp_valid_r <= accept;
      io_rd_r     <= accept && is_io && !cmd.wr;
    end
  end

  assign rsp_valid = rsp_valid_r;

  always_comb begin
    if (io_rd_r)
      rsp.data = io_rd_data;
    else if (half_r)
      rsp.data = mem_rd_data[63:32];
    else
      rsp.data = mem_rd_data[31:0];
    rsp.err = err_any;
  end

endmodule

/* src/pcore_io_regs.sv */
`timescale 1ns/1ps
`include "pcore_params.svh"

module pcore_io_regs #(
  parameter logic [31:0] CORE_ID = 32'd0
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                io_valid,
  input  pcore_pkg::io_req_t  io_req,
  input  logic [63:0]         in_desc,
  input  logic                in_desc_valid,
  input  logic                desc_not_full,
  input  logic                slot_not_full,
  output logic [31:0]         io_rd_data,
  output logic                in_desc_taken,
  output logic                desc_push,
  output pcore_pkg::desc_t    desc_item,
  output logic                slot_push,
  output pcore_pkg::slot_t    slot_item,
  output logic                err_clear
);

  localparam logic [6:0] OFF_DESC       = `PCORE_IO_DESC;
  localparam logic [6:0] OFF_DRAM       = `PCORE_IO_DRAM;
  localparam logic [6:0] OFF_SETTING    = `PCORE_IO_SETTING;
  localparam logic [6:0] OFF_SLOT_INFO  = `PCORE_IO_SLOT_INFO;
  localparam logic [6:0] OFF_RD_DESC    = `PCORE_IO_RD_DESC;
  localparam logic [6:0] OFF_RD_SETTING = `PCORE_IO_RD_SETTING;
  localparam logic [6:0] OFF_STATUS     = `PCORE_IO_STATUS;
  localparam logic [6:0] OFF_ID         = `PCORE_IO_ID;
  localparam logic [6:0] OFF_TIMER      = `PCORE_IO_TIMER;

  logic        wr_en;
  logic        rd_en;
  logic [7:0]  mask8;
  logic [63:0] din;
  logic        strb_bit;
  logic        desc_wen;
  logic        dram_wen;
  logic        setting_wen;
  logic        slot_info_wen;
  logic        send_stb;
  logic        take_stb;
  logic        apply_stb;
  logic        slot_stb;
  logic        timer_rst_stb;
  logic        err_clr_stb;
  logic [63:0] desc_r;
  logic [63:0] dram_r;
  logic [63:0] staged_r;
  logic [63:0] setting_r;
  logic [31:0] slot_info_r;
  logic [31:0] timer_r;
  logic [31:0] rd_data_r;
  logic [31:0] status;
  logic [7:0]  slot_ptr_full;

  function automatic logic [63:0] merge_bytes(input logic [63:0] old_val,
                                              input logic [63:0] new_val,
                                              input logic [7:0]  mask);
    logic [63:0] res;
    res = old_val;
    for (int i = 0; i < 8; i++) begin
      if (mask[i])
        res[i*8 +: 8] = new_val[i*8 +: 8];
    end
    return res;
  endfunction

  //////////////////////////////////////////////////
  // write decode
  //////////////////////////////////////////////////
  assign wr_en = io_valid && io_req.wr;
  assign rd_en = io_valid && !io_req.wr;

  assign mask8 = {4'd0, io_req.mask} << {io_req.off[2], 2'b00};
  assign din   = {io_req.data, io_req.data};

  // bit 0 of the addressed byte lane
  assign strb_bit = io_req.data[{io_req.off[1:0], 3'b000}];

  assign desc_wen      = wr_en && (io_req.off[6:3] == OFF_DESC[6:3]);
  assign dram_wen      = wr_en && (io_req.off[6:3] == OFF_DRAM[6:3]);
  assign setting_wen   = wr_en && (io_req.off[6:3] == OFF_SETTING[6:3]);
  assign slot_info_wen = wr_en && (io_req.off[6:2] == OFF_SLOT_INFO[6:2]);

  assign send_stb      = wr_en && strb_bit && (io_req.off == `PCORE_IO_SEND);
  assign take_stb      = wr_en && strb_bit && (io_req.off == `PCORE_IO_TAKE);
  assign apply_stb     = wr_en && strb_bit && (io_req.off == `PCORE_IO_APPLY);
  assign slot_stb      = wr_en && strb_bit && (io_req.off == `PCORE_IO_SLOT_WR);
  assign timer_rst_stb = wr_en && strb_bit && (io_req.off == `PCORE_IO_TIMER_RST);
  assign err_clr_stb   = wr_en && strb_bit && (io_req.off == `PCORE_IO_ERR_CLR);

  // byte writable registers
  always_ff @(posedge clk) begin
    if (desc_wen)
      desc_r <= merge_bytes(desc_r, din, mask8);
    if (dram_wen)
      dram_r <= merge_bytes(dram_r, din, mask8);
    if (setting_wen)
      staged_r <= merge_bytes(staged_r, din, mask8);
    if (slot_info_wen)
      slot_info_r <= 32'(merge_bytes({32'd0, slot_info_r}, din, mask8));
  end

  // strobe pulses land one cycle after the write
  always_ff @(posedge clk) begin
    if (rst) begin
      setting_r     <= '0;
      desc_push     <= 1'b0;
      slot_push     <= 1'b0;
      in_desc_taken <= 1'b0;
      err_clear     <= 1'b0;
    end else begin
      if (apply_stb)
        setting_r <= staged_r;
      desc_push     <= send_stb;
      slot_push     <= slot_stb;
      in_desc_taken <= take_stb;
      err_clear     <= err_clr_stb;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || timer_rst_stb)
      timer_r <= '0;
    else
      timer_r <= timer_r + 32'd1;
  end

  always_comb begin
    desc_item.desc      = desc_r;
    desc_item.dram_addr = dram_r;
  end

  // software numbers slots from one
  assign slot_ptr_full = slot_info_r[31:24] - 8'd1;

  always_comb begin
    slot_item.ptr  = slot_ptr_full[`PCORE_SLOT_PTR_W-1:0];
    slot_item.addr = slot_info_r[`PCORE_ADDR_W-1:0];
  end

  //////////////////////////////////////////////////
  // read mux
  //////////////////////////////////////////////////
  assign status = {23'd0, slot_not_full, 7'd0, desc_not_full};

  always_ff @(posedge clk) begin
    if (rd_en) begin
      if (io_req.off[6:3] == OFF_RD_DESC[6:3]) begin
        if (!in_desc_valid)
          rd_data_r <= '0;
        else if (io_req.off[2])
          rd_data_r <= in_desc[63:32];
        else
          rd_data_r <= in_desc[31:0];
      end else if (io_req.off[6:3] == OFF_RD_SETTING[6:3]) begin
        rd_data_r <= io_req.off[2] ? setting_r[63:32] : setting_r[31:0];
      end else if (io_req.off[6:2] == OFF_STATUS[6:2]) begin
        rd_data_r <= status;
      end else if (io_req.off[6:2] == OFF_ID[6:2]) begin
        rd_data_r <= CORE_ID;
      end else if (io_req.off[6:2] == OFF_TIMER[6:2]) begin
        rd_data_r <= timer_r;
      end else begin
        rd_data_r <= '0;
      end
    end
  end

  assign io_rd_data = rd_data_r;

endmodule

/* src/pcore_credit_tx.sv */
`timescale 1ns/1ps
`include "pcore_params.svh"

module pcore_credit_tx #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push,
  input  payload_t item,
  input  logic     credit,
  output logic     not_full,
  output logic     overflow,
  output logic     out_valid,
  output payload_t out
);

  localparam int CNT_W = $clog2(`PCORE_CREDITS + 1);

  payload_t         entry [2];
  logic             wr_ptr;
  logic             rd_ptr;
  logic [1:0]       count;
  logic [CNT_W-1:0] credits;
  logic             do_push;

  // full queue drops the push
  assign not_full = (count != 2'd2);
  assign overflow = push && !not_full;
  assign do_push  = push && not_full;

  // head leaves as soon as a credit is left
  assign out_valid = (count != 2'd0) && (credits != '0);
  assign out       = entry[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push)
      entry[wr_ptr] <= item;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= 1'b0;
      rd_ptr  <= 1'b0;
      count   <= 2'd0;
      credits <= CNT_W'(`PCORE_CREDITS);
    end else begin
      if (do_push)
        wr_ptr <= !wr_ptr;
      if (out_valid)
        rd_ptr <= !rd_ptr;
      count   <= count + {1'b0, do_push} - {1'b0, out_valid};
      // one credit per send, one back per returned pulse
      credits <= credits + CNT_W'(credit) - CNT_W'(out_valid);
    end
  end

endmodule

/* src/pcore_err_catch.sv */
`timescale 1ns/1ps
`include "pcore_params.svh"

module pcore_err_catch (
  input  logic                clk,
  input  logic                rst,
  input  logic                cmd_valid,
  input  pcore_pkg::bus_cmd_t cmd,
  input  logic                mem_ready,
  input  logic                desc_overflow,
  input  logic                slot_overflow,
  input  logic                err_clear,
  output logic                err_any
);
  import pcore_pkg::*;

  localparam logic [6:0] OFF_STRB = `PCORE_IO_SEND;

  bus_cmd_t   cmd_r;
  logic       acc_r;
  logic       io_r;
  logic [6:0] off_r;
  logic       mem_range_err;
  logic       io_range_err;
  logic       io_dir_err;
  logic       io_size_err;
  logic [4:0] flags;

  always_ff @(posedge clk) begin
    cmd_r <= cmd;
  end

  always_ff @(posedge clk) begin
    if (rst)
      acc_r <= 1'b0;
    else
      acc_r <= cmd_valid && mem_ready;
  end

  assign io_r  = cmd_r.addr[`PCORE_ADDR_W-1];
  assign off_r = cmd_r.addr[6:0];

  assign mem_range_err = acc_r && !io_r && (32'(cmd_r.addr) >= `PCORE_DMEM_BYTES);
  assign io_range_err  = acc_r && io_r &&
                         (32'(cmd_r.addr[`PCORE_ADDR_W-2:0]) >= `PCORE_IO_SPACE);
  // writes live below 0x40, reads above
  assign io_dir_err    = acc_r && io_r && (cmd_r.wr ? off_r[6] : !off_r[6]);
  assign io_size_err   = acc_r && io_r && (cmd_r.size != 2'd0) &&
                         (off_r[6:3] == OFF_STRB[6:3]);

  // sticky until the clear strobe
  always_ff @(posedge clk) begin
    if (rst || err_clear)
      flags <= '0;
    else
      flags <= flags | {slot_overflow, desc_overflow, io_size_err, io_dir_err,
                        mem_range_err || io_range_err};
  end

  assign err_any = |flags;

endmodule

/* src/pcore_top.sv */
`timescale 1ns/1ps
`include "pcore_params.svh"

module pcore_top #(
  parameter logic [31:0] CORE_ID = 32'd0
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     cmd_valid,
  input  pcore_pkg::bus_cmd_t      cmd,
  input  logic                     mem_ready,
  input  logic [`PCORE_LINE_W-1:0] mem_rd_data,
  input  logic [63:0]              in_desc,
  input  logic                     in_desc_valid,
  input  logic                     desc_credit,
  input  logic                     slot_credit,
  output logic                     rsp_valid,
  output pcore_pkg::bus_rsp_t      rsp,
  output pcore_pkg::line_req_t     line_req,
  output logic                     in_desc_taken,
  output logic                     desc_valid,
  output pcore_pkg::desc_t         desc,
  output logic                     slot_valid,
  output pcore_pkg::slot_t         slot
);
  import pcore_pkg::*;

  logic        io_valid;
  io_req_t     io_req;
  logic [31:0] io_rd_data;
  logic        err_any;
  logic        err_clear;
  logic        desc_push;
  desc_t       desc_item;
  logic        desc_not_full;
  logic        desc_overflow;
  logic        slot_push;
  slot_t       slot_item;
  logic        slot_not_full;
  logic        slot_overflow;

  pcore_bus_adapter adapter_i (
    .clk         (clk),
    .rst         (rst),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .mem_ready   (mem_ready),
    .mem_rd_data (mem_rd_data),
    .io_rd_data  (io_rd_data),
    .err_any     (err_any),
    .line_req    (line_req),
    .io_valid    (io_valid),
    .io_req      (io_req),
    .rsp_valid   (rsp_valid),
    .rsp         (rsp)
  );

  pcore_io_regs #(
    .CORE_ID (CORE_ID)
  ) io_regs_i (
    .clk           (clk),
    .rst           (rst),
    .io_valid      (io_valid),
    .io_req        (io_req),
    .in_desc       (in_desc),
    .in_desc_valid (in_desc_valid),
    .desc_not_full (desc_not_full),
    .slot_not_full (slot_not_full),
    .io_rd_data    (io_rd_data),
    .in_desc_taken (in_desc_taken),
    .desc_push     (desc_push),
    .desc_item     (desc_item),
    .slot_push     (slot_push),
    .slot_item     (slot_item),
    .err_clear     (err_clear)
  );

  // outgoing descriptor and slot senders
  pcore_credit_tx #(
    .payload_t (desc_t)
  ) desc_tx_i (
    .clk       (clk),
    .rst       (rst),
    .push      (desc_push),
    .item      (desc_item),
    .credit    (desc_credit),
    .not_full  (desc_not_full),
    .overflow  (desc_overflow),
    .out_valid (desc_valid),
    .out       (desc)
  );

  pcore_credit_tx #(
    .payload_t (slot_t)
  ) slot_tx_i (
    .clk       (clk),
    .rst       (rst),
    .push      (slot_push),
    .item      (slot_item),
    .credit    (slot_credit),
    .not_full  (slot_not_full),
    .overflow  (slot_overflow),
    .out_valid (slot_valid),
    .out       (slot)
  );

  pcore_err_catch err_catch_i (
    .clk           (clk),
    .rst           (rst),
    .cmd_valid     (cmd_valid),
    .cmd           (cmd),
    .mem_ready     (mem_ready),
    .desc_overflow (desc_overflow),
    .slot_overflow (slot_overflow),
    .err_clear     (err_clear),
    .err_any       (err_any)
  );

endmodule

/* tb/pcore_sva.sv */
`timescale 1ns/1ps
`include "pcore_params.svh"

module pcore_sva (
  input logic clk,
  input logic rst,
  input logic cmd_valid,
  input logic mem_ready,
  input logic rsp_valid,
  input logic desc_valid,
  input logic desc_credit,
  input logic slot_valid,
  input logic in_desc_taken
);

  logic [3:0] desc_outstanding;

  // descriptors sent but not yet returned as credit
  always_ff @(posedge clk) begin
    if (rst)
      desc_outstanding <= '0;
    else
      desc_outstanding <= desc_outstanding + {3'd0, desc_valid} - {3'd0, desc_credit};
  end

  rsp_after_accept: assert property (@(posedge clk) disable iff (rst)
    rsp_valid |-> $past(cmd_valid && mem_ready))
    else $error("response without an accepted command one cycle before");

  quiet_in_reset: assert property (@(posedge clk)
    (rst && $past(rst)) |-> !(rsp_valid || desc_valid || slot_valid || in_desc_taken))
    else $error("valid output while in reset");

  desc_credit_limit: assert property (@(posedge clk) disable iff (rst)
    desc_outstanding <= `PCORE_CREDITS)
    else $error("outstanding descriptors above the credit count");

endmodule

bind pcore_top pcore_sva sva_i (
  .clk           (clk),
  .rst           (rst),
  .cmd_valid     (cmd_valid),
  .mem_ready     (mem_ready),
  .rsp_valid     (rsp_valid),
  .desc_valid    (desc_valid),
  .desc_credit   (desc_credit),
  .slot_valid    (slot_valid),
  .in_desc_taken (in_desc_taken)
);

/* tb/pcore_tb.sv */
`timescale 1ns/1ps
`include "pcore_params.svh"

module pcore_tb;
  import pcore_pkg::*;

  localparam logic [31:0] CORE_ID = 32'h0000_00a5;
  localparam int TIMEOUT = 2000;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic cmd_valid = 1'b0;
  bus_cmd_t cmd = '0;
  logic mem_ready = 1'b0;
  logic [63:0] mem_rd_data = '0;
  logic [63:0] in_desc = '0;
  logic in_desc_valid = 1'b0;
  logic desc_credit = 1'b0;
  logic slot_credit = 1'b0;
  logic rsp_valid;
  bus_rsp_t rsp;
  line_req_t line_req;
  logic in_desc_taken;
  logic desc_valid;
  desc_t desc;
  logic slot_valid;
  slot_t slot;

  // line memory and its shadow
  logic [63:0] mem [4096];
  logic [63:0] shadow_mem [4096];
  logic [31:0] lfsr = 32'h67ce_fe54;
  bus_rsp_t exp_rsp_q [$];
  logic exp_chk_q [$];
  desc_t exp_desc_q [$];
  slot_t exp_slot_q [$];
  logic [7:0] exp_strb;
  logic err_sticky = 1'b0;
  logic [63:0] sh_desc, sh_dram, sh_staged, sh_setting;
  logic [31:0] sh_slot_info;
  int rsp_count = 0;
  int desc_seen = 0;
  int slot_seen = 0;
  int taken_seen = 0;
  int desc_out = 0;
  int slot_out = 0;
  logic desc_credit_en = 1'b0;
  logic [31:0] last_rsp_data;

  pcore_top #(.CORE_ID(CORE_ID)) dut_i (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic fail_value(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
    $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic fail_plain(input string what);
    $display("Error at %0t: %s", $time, what);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_rsp(input bus_rsp_t got, input bus_rsp_t exp, input logic chk);
    if (got.err !== exp.err)
      fail_value("rsp.err", 128'(got.err), 128'(exp.err));
    if (chk && got.data !== exp.data)
      fail_value("rsp.data", 128'(got.data), 128'(exp.data));
  endtask

  task automatic check_desc(input desc_t got, input desc_t exp);
    if (got !== exp)
      fail_value("desc", got, exp);
  endtask

  task automatic check_slot(input slot_t got, input slot_t exp);
    if (got !== exp)
      fail_value("slot", 128'(got), 128'(exp));
  endtask

  task automatic check_strb(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
      fail_value("line_req.strb", 128'(got), 128'(exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
      fail_value(name, 128'(got), 128'(exp));
  endtask

  // expected read data from the shadow state
  function automatic bus_rsp_t pcore_expect(input bus_cmd_t c);
    bus_rsp_t r;
    r.err  = err_sticky;
    r.data = '0;
    if (!c.addr[15]) begin
      r.data = c.addr[2] ? shadow_mem[c.addr[14:3]][63:32] : shadow_mem[c.addr[14:3]][31:0];
    end else begin
      case (c.addr[6:0])
        7'h40: r.data = in_desc_valid ? in_desc[31:0] : 32'd0;
        7'h44: r.data = in_desc_valid ? in_desc[63:32] : 32'd0;
        7'h48: r.data = sh_setting[31:0];
        7'h4C: r.data = sh_setting[63:32];
        7'h54: r.data = CORE_ID;
        default: r.data = '0;
      endcase
    end
    return r;
  endfunction

  function automatic logic [3:0] lane_mask(input logic [1:0] size, input logic [1:0] lo);
    case (size)
      2'd0: return 4'b0001 << lo;
      2'd1: return 4'b0011 << lo;
      default: return 4'b1111;
    endcase
  endfunction

  // memory model, read data one cycle after the request
  initial begin
    for (int i = 0; i < 4096; i++) begin
      mem[i] = {32'(i) * 32'h9e37_79b9, ~32'(i) ^ 32'h5a5a_0000};
      shadow_mem[i] = mem[i];
    end
  end

  always @(posedge clk) begin
    if (line_req.en) begin
      check_strb(line_req.strb, exp_strb);
      mem_rd_data <= mem[line_req.addr[14:3]];
      for (int b = 0; b < 8; b++) begin
        if (line_req.strb[b])
          mem[line_req.addr[14:3]][b*8 +: 8] = line_req.data[b*8 +: 8];
      end
    end
  end

  // ready and credit pulses, only for items in flight
  always @(negedge clk) begin
    logic [31:0] r;
    take_bits(2, r);
    mem_ready = |r[1:0];
    desc_credit = 1'b0;
    slot_credit = 1'b0;
    if (!rst) begin
      if (desc_valid)
        desc_out++;
      if (slot_valid)
        slot_out++;
      take_bits(2, r);
      if (desc_credit_en && desc_out > 0 && r[0]) begin
        desc_credit = 1'b1;
        desc_out--;
      end
      if (slot_out > 0 && r[1]) begin
        slot_credit = 1'b1;
        slot_out--;
      end
    end
  end

  //////////////////////////////////////////////////
  // compare process
  //////////////////////////////////////////////////
  always @(negedge clk) begin
    if (!rst) begin
      if (rsp_valid) begin
        if (exp_rsp_q.size() == 0)
          fail_plain("response with no command outstanding");
        check_rsp(rsp, exp_rsp_q.pop_front(), exp_chk_q.pop_front());
        last_rsp_data = rsp.data;
        rsp_count++;
      end
      if (desc_valid) begin
        if (exp_desc_q.size() == 0)
          fail_plain("descriptor sent that was never queued");
        check_desc(desc, exp_desc_q.pop_front());
        desc_seen++;
      end
      if (slot_valid) begin
        if (exp_slot_q.size() == 0)
          fail_plain("slot sent that was never queued");
        check_slot(slot, exp_slot_q.pop_front());
        slot_seen++;
      end
      if (in_desc_taken)
        taken_seen++;
    end
  end

  // one bus access, shadow updated as the DUT should
  task automatic bus_access(input logic wr, input logic [15:0] addr, input logic [31:0] data,
                            input logic [1:0] size, input logic chk,
                            output logic [31:0] rdata);
    bus_cmd_t c;
    logic [3:0] m;
    int start;
    int t;
    c = '{wr: wr, addr: addr, data: data, size: size};
    m = lane_mask(size, addr[1:0]);
    exp_strb = wr ? ({4'd0, m} << {addr[2], 2'b00}) : 8'd0;
    exp_rsp_q.push_back(pcore_expect(c));
    exp_chk_q.push_back(chk && !wr);
    if (wr && !addr[15]) begin
      for (int b = 0; b < 4; b++) begin
        if (m[b])
          shadow_mem[addr[14:3]][{addr[2], 2'(b), 3'd0} +: 8] = data[b*8 +: 8];
      end
    end else if (wr) begin
      case (addr[6:0])
        7'h00: sh_desc[31:0] = data;
        7'h04: sh_desc[63:32] = data;
        7'h08: sh_dram[31:0] = data;
        7'h0C: sh_dram[63:32] = data;
        7'h10: sh_staged[31:0] = data;
        7'h14: sh_staged[63:32] = data;
        7'h18: sh_slot_info = data;
        7'h38: exp_desc_q.push_back('{desc: sh_desc, dram_addr: sh_dram});
        7'h3A: sh_setting = sh_staged;
        7'h3B: exp_slot_q.push_back('{ptr: 3'(sh_slot_info[31:24] - 8'd1),
                                       addr: sh_slot_info[15:0]});
        7'h3D: err_sticky = 1'b0;
        default: ;
      endcase
    end
    start = rsp_count;
    @(negedge clk);
    cmd_valid = 1'b1;
    cmd = c;
    t = 0;
    do begin
      @(posedge clk);
      t++;
      if (t > TIMEOUT)
        fail_plain("command never accepted");
    end while (!mem_ready);
    @(negedge clk);
    cmd_valid = 1'b0;
    t = 0;
    do begin
      @(posedge clk);
      t++;
      if (t > TIMEOUT)
        fail_plain("no response to an accepted command");
    end while (rsp_count == start);
    rdata = last_rsp_data;
  endtask

  task automatic send_strobe(input logic [6:0] off);
    logic [31:0] d;
    bus_access(1'b1, {9'h100, off}, 32'h0101_0101, 2'd0, 1'b0, d);
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] d;
    logic [15:0] a;
    logic [15:0] words [$];
    int t;
    sh_desc = '0;
    sh_dram = '0;
    sh_staged = '0;
    sh_setting = '0;
    sh_slot_info = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    ////////////////////////////////////////////////
    // memory writes of every size, then word reads
    ////////////////////////////////////////////////
    for (int i = 0; i < 16; i++) begin
      take_bits(32, r);
      a = 16'h0200 | (r[15:0] & 16'h00fc);
      case (r[17:16] % 3)
        0: a = a | {14'd0, r[19:18]};
        1: a = a | {14'd0, r[19], 1'b0};
        default: ;
      endcase
      bus_access(1'b1, a, r ^ 32'h3c3c_c3c3, 2'(r[17:16] % 3), 1'b0, d);
      words.push_back({a[15:2], 2'b00});
    end
    foreach (words[i])
      bus_access(1'b0, words[i], 32'd0, 2'd2, 1'b1, d);

    ////////////////////////////////////////////////
    // descriptors with credits withheld
    ////////////////////////////////////////////////
    for (int i = 0; i < `PCORE_CREDITS + 2; i++) begin
      bus_access(1'b1, 16'h8000, 32'hd000_0000 + i, 2'd2, 1'b0, d);
      bus_access(1'b1, 16'h8004, 32'hd100_0000 + i, 2'd2, 1'b0, d);
      bus_access(1'b1, 16'h8008, 32'ha000_0040 * (i + 1), 2'd2, 1'b0, d);
      bus_access(1'b1, 16'h800C, 32'ha100_0000 + i, 2'd2, 1'b0, d);
      send_strobe(7'h38);
    end
    t = 0;
    do begin
      bus_access(1'b0, 16'h8050, 32'd0, 2'd2, 1'b0, d);
      t++;
      if (t > 50)
        fail_plain("descriptor queue never filled");
    end while (d[0]);
    check_count("desc_seen", desc_seen, `PCORE_CREDITS);
    desc_credit_en = 1'b1;
    t = 0;
    while (desc_seen < `PCORE_CREDITS + 2) begin
      @(posedge clk);
      t++;
      if (t > TIMEOUT)
        fail_plain("queued descriptors never left");
    end

    ////////////////////////////////////////////////
    // staged setting and apply
    ////////////////////////////////////////////////
    bus_access(1'b1, 16'h8010, 32'h5e77_0001, 2'd2, 1'b0, d);
    bus_access(1'b1, 16'h8014, 32'h5e77_0002, 2'd2, 1'b0, d);
    bus_access(1'b0, 16'h8048, 32'd0, 2'd2, 1'b1, d);
    bus_access(1'b0, 16'h804C, 32'd0, 2'd2, 1'b1, d);
    send_strobe(7'h3A);
    bus_access(1'b0, 16'h8048, 32'd0, 2'd2, 1'b1, d);
    bus_access(1'b0, 16'h804C, 32'd0, 2'd2, 1'b1, d);

    ////////////////////////////////////////////////
    // incoming descriptor, take and slot strobes
    ////////////////////////////////////////////////
    bus_access(1'b0, 16'h8040, 32'd0, 2'd2, 1'b1, d);
    @(negedge clk);
    in_desc = 64'h1122_3344_5566_7788;
    in_desc_valid = 1'b1;
    bus_access(1'b0, 16'h8040, 32'd0, 2'd2, 1'b1, d);
    bus_access(1'b0, 16'h8044, 32'd0, 2'd2, 1'b1, d);
    send_strobe(7'h39);
    check_count("in_desc_taken pulses", taken_seen, 1);
    bus_access(1'b1, 16'h8018, 32'h0500_1234, 2'd2, 1'b0, d);
    send_strobe(7'h3B);
    t = 0;
    while (slot_seen < 1) begin
      @(posedge clk);
      t++;
      if (t > TIMEOUT)
        fail_plain("slot write never sent");
    end

    ////////////////////////////////////////////////
    // sticky error, id and timer
    ////////////////////////////////////////////////
    bus_access(1'b0, 16'h8060, 32'd0, 2'd2, 1'b1, d);
    // flag shows from the next response on
    err_sticky = 1'b1;
    bus_access(1'b0, words[0], 32'd0, 2'd2, 1'b1, d);
    bus_access(1'b0, words[1], 32'd0, 2'd2, 1'b1, d);
    send_strobe(7'h3D);
    bus_access(1'b0, words[2], 32'd0, 2'd2, 1'b1, d);
    bus_access(1'b0, 16'h8054, 32'd0, 2'd2, 1'b1, d);
    bus_access(1'b0, 16'h8058, 32'd0, 2'd2, 1'b0, r);
    bus_access(1'b0, 16'h8058, 32'd0, 2'd2, 1'b0, d);
    if (d <= r)
      fail_plain("timer did not increase between reads");

    $display("Everything OK");
    $finish;
  end

endmodule

/* pcore.f */
+incdir+include
src/pcore_pkg.sv
src/pcore_bus_adapter.sv
src/pcore_io_regs.sv
src/pcore_credit_tx.sv
src/pcore_err_catch.sv
src/pcore_top.sv
tb/pcore_sva.sv
tb/pcore_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the pcore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module pcore_tb -f pcore.f || exit 1

out=$(./obj_dir/Vpcore_tb 2>&1)
echo "$out"
echo "$out" | grep -q "Everything OK" && exit 0 || exit 1
